//--- build.f
source/op_pkg.sv
source/inst_decoder.sv
source/op_queue.sv
source/exec_unit.sv
source/core_front.sv
bench/core_front_chk.sv
bench/core_front_tb.sv

//--- run.sh
#!/bin/sh
# compile and run core_front_tb with Verilator, result taken from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module core_front_tb \
  -Mdir obj_dir -o sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } ||
grep -q "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/core_front_tb.sv
`timescale 1ns/1ps

module core_front_tb;
  import op_pkg::*;

  localparam int N_WORDS   = 300;
  localparam int LIMIT     = 4 * N_WORDS + 200;  // cycles
  localparam int PIPE_FULL = 16;                 // 15 queued plus decoder register

  logic    clk_in;
  logic    rst_in;
  logic    rdy_in;
  logic    inst_valid;
  word_t   inst;
  word_t   inst_addr;
  logic    fetch_stall;
  logic    retire_valid;
  retire_t retire;

  word_t words [$];       // expected-word list in fetch order
  word_t model_rf [32];
  word_t rng;
  int    accepted;
  int    retired;
  int    idx;
  int    cyc;
  logic  take_now;
  logic  rdy_last;
  logic  saw_stall;
  int    acc_edge [$];    // edge at which each word was taken
  logic  acc_idle [$];    // word found nothing in flight
  logic  rdy_hist [$];    // rdy_in per edge, entry 0 is edge 1

  core_front dut0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_addr    (inst_addr),
    .fetch_stall  (fetch_stall),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #4 clk_in = ~clk_in;

  function automatic word_t xorshift(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t addr_of(input int i);
    return 32'h0000_1000 + word_t'(i) * 32'd4;
  endfunction

  // r gives kind and register fields, s gives immediate bits
  function automatic word_t make_word(input word_t r, input word_t s);
    logic [2:0] f3;
    logic [2:0] sel;
    logic [6:0] f7;
    f3  = r[14:12];
    sel = {r[13], 1'b0, r[12]};  // beq bne blt bge
    f7  = (r[25] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd15: return {f7, r[24:20], r[19:15], f3, r[11:7], 7'h33};
      4'd3, 4'd4, 4'd5: begin
        if (f3 == 3'd1 || f3 == 3'd5)  // shifts by shamt
          return {f7, s[24:20], r[19:15], f3, r[11:7], 7'h13};
        return {s[31:20], r[19:15], f3, r[11:7], 7'h13};
      end
      4'd6:  return {s[31:12], r[11:7], 7'h37};
      4'd7:  return {s[31:12], r[11:7], 7'h17};
      4'd8:  return {s[31:12], r[11:7], 7'h6f};
      4'd9:  return {s[31:20], r[19:15], 3'b000, r[11:7], 7'h67};
      4'd10, 4'd11: return {s[31:25], r[24:20], r[19:15], sel, s[11:7], 7'h63};
      4'd12: return {s[31:20], r[19:15], (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3,
                     r[11:7], 7'h03};
      4'd13: return {s[31:25], r[24:20], r[19:15], (f3 > 3'd2) ? 3'd2 : f3,
                     s[11:7], 7'h23};
      default: return {s[31:7], 7'h7f};  // no such opcode
    endcase
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected retire record, updates model_rf
  function automatic retire_t compute_retire(input word_t w, input word_t a);
    retire_t    e;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a1;
    word_t      a2;
    word_t      imm;
    word_t      res;
    logic       writes;
    f3     = w[14:12];
    f7     = w[31:25];
    a1     = model_rf[w[19:15]];
    a2     = model_rf[w[24:20]];
    imm    = '0;
    res    = '0;
    writes = 1'b0;
    e      = '0;
    case (w[6:0])
      7'h33: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        writes = 1'b1;
        res    = alu_ref(f3, f7[5], a1, a2);
      end
      7'h13: if ((f3 != 3'd1 && f3 != 3'd5) || (f3 == 3'd1 && f7 == 7'h00) ||
                 (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20))) begin
        imm    = {{20{w[31]}}, w[31:20]};
        writes = 1'b1;
        res    = alu_ref(f3, f3 == 3'd5 && f7[5], a1, imm);
      end
      7'h37: begin
        imm    = {w[31:12], 12'b0};
        writes = 1'b1;
        res    = imm;
      end
      7'h17: begin
        imm    = {w[31:12], 12'b0};
        writes = 1'b1;
        res    = a + imm;
      end
      7'h6f: begin
        imm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        writes  = 1'b1;
        res     = a + 32'd4;
        e.taken = 1'b1;
      end
      7'h67: if (f3 == 3'd0) begin
        imm     = {{20{w[31]}}, w[31:20]};
        writes  = 1'b1;
        res     = a + 32'd4;
        e.taken = 1'b1;
      end
      7'h63: if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd5) begin
        imm      = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.branch = 1'b1;
        case (f3)
          3'd0: e.taken = (a1 == a2);
          3'd1: e.taken = (a1 != a2);
          3'd4: e.taken = ($signed(a1) < $signed(a2));
          default: e.taken = ($signed(a1) >= $signed(a2));
        endcase
      end
      7'h03: if (f3 != 3'd3 && f3 < 3'd6) imm = {{20{w[31]}}, w[31:20]};
      7'h23: if (f3 < 3'd3) imm = {{20{w[31]}}, w[31:25], w[11:7]};
      default: imm = '0;
    endcase
    e.addr   = a;
    e.rd     = w[11:7];
    e.wr_en  = writes && (w[11:7] != 5'd0);
    e.value  = e.wr_en ? res : '0;
    e.target = (w[6:0] == 7'h67 && f3 == 3'd0) ? ((a1 + imm) & ~32'd1) : (a + imm);
    if (e.wr_en) model_rf[w[11:7]] = res;
    return e;
  endfunction

  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_retire(input retire_t expected, input retire_t got);
    if (got !== expected)
      report_fail($sformatf({"retire at %h: exp rd=%0d wr=%b val=%h br=%b tk=%b tgt=%h,",
        " got addr=%h rd=%0d wr=%b val=%h br=%b tk=%b tgt=%h"},
        expected.addr, expected.rd, expected.wr_en, expected.value, expected.branch,
        expected.taken, expected.target, got.addr, got.rd, got.wr_en, got.value,
        got.branch, got.taken, got.target));
  endtask

  task automatic check_stall(input logic expected, input logic got);
    if (got !== expected)
      report_fail($sformatf("fetch_stall exp %b got %b with %0d words in flight",
        expected, got, accepted - retired));
  endtask

  // decoder and queue stages put the pop two edges after acceptance at the earliest
  task automatic verify_latency(input int n, input int pop_edge);
    int earliest;
    earliest = acc_edge[n] + 2;
    if (pop_edge < earliest ||
        (acc_idle[n] && rdy_hist[earliest - 1] && pop_edge != earliest))
      report_fail($sformatf("word %0d taken at edge %0d retired at edge %0d, exp %0d",
        n, acc_edge[n], pop_edge, earliest));
  endtask

  // compare process, everything is stable at the falling edge
  always @(negedge clk_in) begin
    if (!rst_in) begin
      if (retire_valid) begin
        if (!rdy_last) report_fail("retire while rdy_in was low");
        if (retired >= N_WORDS) report_fail("more retires than fetched words");
        verify_latency(retired, cyc);
        check_retire(compute_retire(words[retired], addr_of(retired)), retire);
        retired++;
      end
      check_stall(accepted - retired >= PIPE_FULL, fetch_stall);
      if (fetch_stall) saw_stall = 1'b1;
      take_now = inst_valid && !fetch_stall;  // taken at the coming edge
      if (take_now) begin
        acc_edge.push_back(cyc + 1);
        acc_idle.push_back(accepted == retired);  // nothing ahead of it
        accepted++;
      end
      rdy_hist.push_back(rdy_in);  // value seen at edge cyc + 1
      rdy_last = rdy_in;
    end
  end

  always @(posedge clk_in) begin
    if (!rst_in) cyc++;
    if (cyc >= LIMIT) begin
      $display("timeout: only %0d of %0d words retired after %0d cycles",
        retired, N_WORDS, cyc);
      $display("test failed");
      $fatal(1);
    end
  end

  // fetch side, holds the word until it is taken
  initial begin
    wait (!rst_in);
    forever begin
      @(posedge clk_in);
      #1;
      if (take_now) idx++;
      take_now   = 1'b0;
      inst_valid = (idx < N_WORDS);
      inst       = (idx < N_WORDS) ? words[idx] : '0;
      inst_addr  = addr_of(idx);
    end
  end

  // rdy_in: two fixed pauses, random elsewhere
  initial begin
    wait (!rst_in);
    forever begin
      @(posedge clk_in);
      #1;
      rng = xorshift(rng);
      if ((cyc >= 20 && cyc < 50) || (cyc >= 200 && cyc < 230)) rdy_in = 1'b0;
      else if (cyc < 80) rdy_in = 1'b1;
      else rdy_in = (rng[1:0] != 2'b00);
    end
  end

  initial begin
    clk_in     = 1'b0;
    rst_in     = 1'b1;
    rdy_in     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    inst_addr  = '0;
    accepted   = 0;
    retired    = 0;
    idx        = 0;
    cyc        = 0;
    take_now   = 1'b0;
    rdy_last   = 1'b0;
    saw_stall  = 1'b0;
    rng        = 32'h969a;
    for (int i = 0; i < 32; i++) model_rf[i] = '0;
    for (int i = 0; i < N_WORDS; i++) begin
      word_t r;
      word_t s;
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      s   = rng;
      words.push_back(make_word(r, s));
    end
    repeat (4) @(posedge clk_in);
    #1 rst_in = 1'b0;
    wait (retired == N_WORDS);
    repeat (20) @(posedge clk_in);  // catch stray retires
    if (!saw_stall) begin
      $display("fetch_stall never rose during the rdy_in pauses");
      $display("test failed");
      $fatal(1);
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- bench/core_front_chk.sv
`timescale 1ns/1ps

module core_front_chk (
  input logic              clk_in,
  input logic              rst_in,
  input logic              rdy_in,
  input logic              push,
  input logic              foq_full,
  input logic              head_valid,
  input op_pkg::foq_idx_t  front,
  input op_pkg::foq_idx_t  rear
);
  import op_pkg::*;

  // rear may not move while the queue is full
  assert property (@(posedge clk_in) disable iff (rst_in)
    foq_full |=> $stable(rear))
    else $error("queue pushed while full");

  assert property (@(posedge clk_in)
    rst_in |=> !head_valid)
    else $error("head_valid high right after reset");

  // nothing to pop and nothing to push
  assert property (@(posedge clk_in) disable iff (rst_in)
    (!rdy_in && !push) |=> ($stable(front) && $stable(rear)))
    else $error("queue pointers moved while idle");

endmodule

bind op_queue core_front_chk chk0 (
  .clk_in     (clk_in),
  .rst_in     (rst_in),
  .rdy_in     (rdy_in),
  .push       (push),
  .foq_full   (foq_full),
  .head_valid (head_valid),
  .front      (front),
  .rear       (rear)
);

//--- source/core_front.sv
`timescale 1ns/1ps

module core_front (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            inst_valid,
  input  op_pkg::word_t   inst,
  input  op_pkg::word_t   inst_addr,
  output logic            fetch_stall,
  output logic            retire_valid,
  output op_pkg::retire_t retire
);
  import op_pkg::*;

  logic    dec_valid;
  dec_op_t dec_op;
  logic    foq_full;
  logic    head_valid;   // queue non-empty
  dec_op_t head_op;

  inst_decoder u_dec (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_addr   (inst_addr),
    .foq_full    (foq_full),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .fetch_stall (fetch_stall)
  );

  op_queue u_foq (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .push       (dec_valid),
    .push_op    (dec_op),
    .head_valid (head_valid),
    .head_op    (head_op),
    .foq_full   (foq_full)
  );

  exec_unit u_exec (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .head_valid   (head_valid),
    .head_op      (head_op),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

//--- source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            head_valid,
  input  op_pkg::dec_op_t head_op,
  output logic            retire_valid,
  output op_pkg::retire_t retire
);
  import op_pkg::*;

  word_t regs [32];
  word_t rs1_val;
  word_t rs2_val;
  word_t opb;
  word_t result;
  word_t target;
  logic  writes_rd;
  logic  wr_en;
  logic  taken;
  logic  fire;

  assign fire = head_valid && rdy_in;  // head consumed at this edge

  // x0 is never written, so it reads zero
  assign rs1_val = regs[head_op.rs1];
  assign rs2_val = regs[head_op.rs2];
  assign opb     = head_op.use_imm ? head_op.imm : rs2_val;

  always_comb begin
    result    = '0;
    writes_rd = 1'b1;
    taken     = 1'b0;
    case (head_op.op)
      OP_ADD:   result = rs1_val + opb;
      OP_SUB:   result = rs1_val - opb;
      OP_AND:   result = rs1_val & opb;
      OP_OR:    result = rs1_val | opb;
      OP_XOR:   result = rs1_val ^ opb;
      OP_SLT:   result = {31'b0, $signed(rs1_val) < $signed(opb)};
      OP_SLTU:  result = {31'b0, rs1_val < opb};
      OP_SLL:   result = rs1_val << opb[4:0];
      OP_SRL:   result = rs1_val >> opb[4:0];
      OP_SRA:   result = word_t'($signed(rs1_val) >>> opb[4:0]);
      OP_LUI:   result = head_op.imm;
      OP_AUIPC: result = head_op.addr + head_op.imm;
      OP_JAL, OP_JALR: begin
        result = head_op.addr + 32'd4;  // link address
        taken  = 1'b1;
      end
      // branches compare the two registers, never imm
      OP_BEQ: begin
        writes_rd = 1'b0;
        taken     = (rs1_val == rs2_val);
      end
      OP_BNE: begin
        writes_rd = 1'b0;
        taken     = (rs1_val != rs2_val);
      end
      OP_BLT: begin
        writes_rd = 1'b0;
        taken     = ($signed(rs1_val) < $signed(rs2_val));
      end
      OP_BGE: begin
        writes_rd = 1'b0;
        taken     = ($signed(rs1_val) >= $signed(rs2_val));
      end
      default: writes_rd = 1'b0;  // load, store, illegal
    endcase
  end

  assign wr_en  = writes_rd && (head_op.rd != '0);
  assign target = (head_op.op == OP_JALR) ? ((rs1_val + head_op.imm) & ~32'd1)
                                          : (head_op.addr + head_op.imm);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (fire && wr_en) begin
      regs[head_op.rd] <= result;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= fire;  // one cycle per popped op
    end
  end

  always_ff @(posedge clk_in) begin
    if (fire) begin
      retire.addr   <= head_op.addr;
      retire.rd     <= head_op.rd;
      retire.wr_en  <= wr_en;
      retire.value  <= wr_en ? result : '0;
      retire.branch <= head_op.branch;
      retire.taken  <= taken;
      retire.target <= target;
    end
  end

endmodule

//--- source/op_queue.sv
`timescale 1ns/1ps

module op_queue (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  logic            push,
  input  op_pkg::dec_op_t push_op,
  output logic            head_valid,
  output op_pkg::dec_op_t head_op,
  output logic            foq_full
);
  import op_pkg::*;

  dec_op_t  mem [FOQ_DEPTH];
  foq_idx_t front;   // oldest entry
  foq_idx_t rear;    // next free slot
  foq_idx_t rear_inc;
  logic     do_push;
  logic     do_pop;

  assign rear_inc = rear + foq_idx_t'(1);

  // one slot always stays empty, so full and empty differ
  assign head_valid = (front != rear);
  assign foq_full   = (rear_inc == front);

  assign head_op = head_valid ? mem[front] : '0;

  assign do_push = push && !foq_full;
  // rdy_in only holds back the consumer side
  assign do_pop  = head_valid && rdy_in;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      front <= '0;
      rear  <= '0;
    end else begin
      if (do_pop) begin
        front <= front + foq_idx_t'(1);  // wraps at FOQ_DEPTH
      end
      if (do_push) begin
        rear <= rear_inc;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      mem[rear] <= push_op;
    end
  end

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            inst_valid,
  input  op_pkg::word_t   inst,
  input  op_pkg::word_t   inst_addr,
  input  logic            foq_full,
  output logic            dec_valid,
  output op_pkg::dec_op_t dec_op,
  output logic            fetch_stall
);
  import op_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  dec_op_t    dec_next;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec_next      = '0;
    dec_next.op   = OP_ILLEGAL;
    dec_next.rd   = inst[11:7];
    dec_next.rs1  = inst[19:15];
    dec_next.rs2  = inst[24:20];
    dec_next.addr = inst_addr;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000: dec_next.op = OP_ADD;
            3'b001: dec_next.op = OP_SLL;
            3'b010: dec_next.op = OP_SLT;
            3'b011: dec_next.op = OP_SLTU;
            3'b100: dec_next.op = OP_XOR;
            3'b101: dec_next.op = OP_SRL;
            3'b110: dec_next.op = OP_OR;
            default: dec_next.op = OP_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'b000) dec_next.op = OP_SUB;
          else if (funct3 == 3'b101) dec_next.op = OP_SRA;
        end
      end
      OPC_OP_IMM: begin
        dec_next.use_imm = 1'b1;
        dec_next.imm     = imm_i;
        case (funct3)
          3'b000: dec_next.op = OP_ADD;
          3'b010: dec_next.op = OP_SLT;
          3'b011: dec_next.op = OP_SLTU;
          3'b100: dec_next.op = OP_XOR;
          3'b110: dec_next.op = OP_OR;
          3'b111: dec_next.op = OP_AND;
          3'b001: if (funct7 == F7_BASE) dec_next.op = OP_SLL;
          default: begin  // 101, shamt in imm[4:0]
            if (funct7 == F7_BASE) dec_next.op = OP_SRL;
            else if (funct7 == F7_ALT) dec_next.op = OP_SRA;
          end
        endcase
      end
      OPC_LUI: begin
        dec_next.op      = OP_LUI;
        dec_next.use_imm = 1'b1;
        dec_next.imm     = imm_u;
      end
      OPC_AUIPC: begin
        dec_next.op      = OP_AUIPC;
        dec_next.use_imm = 1'b1;
        dec_next.imm     = imm_u;
      end
      OPC_JAL: begin
        dec_next.op  = OP_JAL;
        dec_next.imm = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) dec_next.op = OP_JALR;
        dec_next.use_imm = 1'b1;
        dec_next.jalr    = 1'b1;
        dec_next.imm     = imm_i;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000: dec_next.op = OP_BEQ;
          3'b001: dec_next.op = OP_BNE;
          3'b100: dec_next.op = OP_BLT;
          3'b101: dec_next.op = OP_BGE;
          default: dec_next.op = OP_ILLEGAL;  // bltu/bgeu not covered
        endcase
        dec_next.branch = 1'b1;
        dec_next.imm    = imm_b;
      end
      OPC_LOAD: begin
        if (funct3 != 3'b011 && funct3 < 3'b110) dec_next.op = OP_LOAD;
        dec_next.ls      = 1'b1;
        dec_next.use_imm = 1'b1;
        dec_next.imm     = imm_i;
      end
      OPC_STORE: begin
        if (funct3 < 3'b011) dec_next.op = OP_STORE;
        dec_next.ls      = 1'b1;
        dec_next.use_imm = 1'b1;
        dec_next.imm     = imm_s;
      end
      default: dec_next.op = OP_ILLEGAL;
    endcase
    // unknown encodings carry no flags
    if (dec_next.op == OP_ILLEGAL) begin
      dec_next.imm     = '0;
      dec_next.branch  = 1'b0;
      dec_next.ls      = 1'b0;
      dec_next.use_imm = 1'b0;
      dec_next.jalr    = 1'b0;
    end
  end

  assign fetch_stall = dec_valid && foq_full;  // held word cannot be pushed

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      dec_valid <= 1'b0;
    end else if (!fetch_stall) begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!fetch_stall && inst_valid) begin
      dec_op <= dec_next;
    end
  end

endmodule

//--- source/op_pkg.sv
package op_pkg;

  typedef logic [31:0] word_t;   // data, address or instruction
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  op_t;

  // internal op codes
  localparam op_t OP_ADD     = 5'd0;
  localparam op_t OP_SUB     = 5'd1;
  localparam op_t OP_AND     = 5'd2;
  localparam op_t OP_OR      = 5'd3;
  localparam op_t OP_XOR     = 5'd4;
  localparam op_t OP_SLT     = 5'd5;
  localparam op_t OP_SLTU    = 5'd6;
  localparam op_t OP_SLL     = 5'd7;
  localparam op_t OP_SRL     = 5'd8;
  localparam op_t OP_SRA     = 5'd9;
  localparam op_t OP_LUI     = 5'd10;
  localparam op_t OP_AUIPC   = 5'd11;
  localparam op_t OP_JAL     = 5'd12;
  localparam op_t OP_JALR    = 5'd13;
  localparam op_t OP_BEQ     = 5'd14;
  localparam op_t OP_BNE     = 5'd15;
  localparam op_t OP_BLT     = 5'd16;
  localparam op_t OP_BGE     = 5'd17;
  localparam op_t OP_LOAD    = 5'd18;
  localparam op_t OP_STORE   = 5'd19;
  localparam op_t OP_ILLEGAL = 5'd20;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

  localparam int FOQ_DEPTH_W = 4;
  localparam int FOQ_DEPTH   = 1 << FOQ_DEPTH_W;

  typedef logic [FOQ_DEPTH_W-1:0] foq_idx_t;

  typedef struct packed {
    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     branch;   // b-type
    logic     ls;       // load or store
    logic     use_imm;
    logic     jalr;
    word_t    addr;
  } dec_op_t;

  typedef struct packed {
    word_t    addr;
    reg_idx_t rd;
    logic     wr_en;
    word_t    value;    // write-back data
    logic     branch;
    logic     taken;
    word_t    target;
  } retire_t;

endpackage
